// File: hdl/rvPkg.sv
// RV32I core package with widths, opcodes, ALU operations and stage payloads
package rvPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 256;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } aluOpE;

    typedef enum logic [1:0] {
        FWD_RF    = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwdSelE;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1Val;
        logic [XLEN-1:0]       rs2Val;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        aluOpE                 aluOp;
        logic                  useImm;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic                  isBranch;
        logic                  branchNe;  // bne when set, beq otherwise
        logic                  isJal;
        logic                  isLui;
    } idExT;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic [XLEN-1:0]       result;    // ALU value, lui immediate or link address
        logic [XLEN-1:0]       storeData;
    } exMemT;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  regWrite;
        logic [XLEN-1:0]       data;
    } memWbT;

endpackage

// File: hdl/regFile.sv
// Register file with 31 writable entries, x0 tied to zero and write-through reads
`timescale 1ns/1ps

module regFile (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic [rvPkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rvPkg::REG_ADDR_W-1:0] rs2_i,
    output logic [rvPkg::XLEN-1:0]       rs1Data_o,
    output logic [rvPkg::XLEN-1:0]       rs2Data_o,
    input  rvPkg::memWbT                 wb_i
);

    logic [rvPkg::XLEN-1:0] regs [32];
    logic                   wrEn;

    assign wrEn = wb_i.valid && wb_i.regWrite && (wb_i.rd != '0);  // x0 is never written

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Same-cycle write is visible to decode
    assign rs1Data_o = (wrEn && wb_i.rd == rs1_i) ? wb_i.data : regs[rs1_i];
    assign rs2Data_o = (wrEn && wb_i.rd == rs2_i) ? wb_i.data : regs[rs2_i];

    // x0 stays zero even while writeback targets it
    x0ReadsZero: assert property (@(posedge clk_i) disable iff (reset_i)
        (rs1_i == '0 |-> rs1Data_o == '0) and (rs2_i == '0 |-> rs2Data_o == '0));

endmodule

// File: hdl/fetchStage.sv
// Fetch stage holding the program counter and the IF/ID register
`timescale 1ns/1ps

module fetchStage (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   redirect_i,
    input  logic [rvPkg::XLEN-1:0] target_i,
    output logic [rvPkg::XLEN-1:0] imemAddr_o,
    input  logic [rvPkg::XLEN-1:0] imemData_i,
    output logic [rvPkg::XLEN-1:0] ifPc_o,
    output logic [rvPkg::XLEN-1:0] ifInstr_o,
    output logic                   ifValid_o
);

    logic [rvPkg::XLEN-1:0] pc;

    assign imemAddr_o = pc;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc <= rvPkg::RESET_PC;
        end else if (redirect_i) begin
            pc <= target_i;  // Taken branch or jal wins over stall
        end else if (!stall_i) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            ifValid_o <= 1'b0;
        end else if (!stall_i) begin
            ifValid_o <= 1'b1;
            ifPc_o    <= pc;
            ifInstr_o <= imemData_i;
        end
    end

endmodule

// File: hdl/decodeStage.sv
// Decode stage with control decode, immediate generation and the ID/EX register
`timescale 1ns/1ps

module decodeStage (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         stall_i,
    input  logic                         flush_i,
    input  logic [rvPkg::XLEN-1:0]       ifPc_i,
    input  logic [rvPkg::XLEN-1:0]       ifInstr_i,
    input  logic                         ifValid_i,
    input  rvPkg::memWbT                 wb_i,
    output logic [rvPkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rvPkg::REG_ADDR_W-1:0] rs2_o,
    output rvPkg::idExT                  idEx_o
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [rvPkg::XLEN-1:0] rs1Data;
    logic [rvPkg::XLEN-1:0] rs2Data;
    rvPkg::idExT            idExD;

    function automatic rvPkg::aluOpE aluFromFunct(input logic [2:0] f3, input logic isSub);
        case (f3)
            3'b000:  return isSub ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            3'b001:  return rvPkg::ALU_SLL;
            3'b010:  return rvPkg::ALU_SLT;
            3'b100:  return rvPkg::ALU_XOR;
            3'b101:  return rvPkg::ALU_SRL;
            3'b110:  return rvPkg::ALU_OR;
            3'b111:  return rvPkg::ALU_AND;
            default: return rvPkg::ALU_ADD;
        endcase
    endfunction

    assign opcode = ifInstr_i[6:0];
    assign funct3 = ifInstr_i[14:12];
    assign rs1_o  = ifInstr_i[19:15];
    assign rs2_o  = ifInstr_i[24:20];

    regFile rf (
        .clk_i(clk_i), .reset_i(reset_i), .rs1_i(rs1_o), .rs2_i(rs2_o),
        .rs1Data_o(rs1Data), .rs2Data_o(rs2Data), .wb_i(wb_i)
    );

    always_comb begin
        idExD          = '0;
        idExD.valid    = ifValid_i;
        idExD.pc       = ifPc_i;
        idExD.rs1Val   = rs1Data;
        idExD.rs2Val   = rs2Data;
        idExD.rs1      = rs1_o;
        idExD.rs2      = rs2_o;
        idExD.rd       = ifInstr_i[11:7];
        idExD.aluOp    = rvPkg::ALU_ADD;
        case (opcode)
            rvPkg::OP_REG: begin
                idExD.regWrite = 1'b1;
                idExD.aluOp    = aluFromFunct(funct3, ifInstr_i[30]);
            end
            rvPkg::OP_IMM: begin
                idExD.regWrite = 1'b1;
                idExD.useImm   = 1'b1;
                idExD.aluOp    = aluFromFunct(funct3, 1'b0);  // No subi
                idExD.imm      = {{20{ifInstr_i[31]}}, ifInstr_i[31:20]};
            end
            rvPkg::OP_LUI: begin
                idExD.regWrite = 1'b1;
                idExD.isLui    = 1'b1;
                idExD.imm      = {ifInstr_i[31:12], 12'b0};
            end
            rvPkg::OP_LOAD: begin
                idExD.regWrite = 1'b1;
                idExD.memRead  = 1'b1;
                idExD.useImm   = 1'b1;
                idExD.imm      = {{20{ifInstr_i[31]}}, ifInstr_i[31:20]};
            end
            rvPkg::OP_STORE: begin
                idExD.memWrite = 1'b1;
                idExD.useImm   = 1'b1;
                idExD.imm      = {{20{ifInstr_i[31]}}, ifInstr_i[31:25], ifInstr_i[11:7]};
            end
            rvPkg::OP_BRANCH: begin
                idExD.isBranch = 1'b1;
                idExD.branchNe = funct3[0];
                idExD.imm      = {{19{ifInstr_i[31]}}, ifInstr_i[31], ifInstr_i[7],
                                  ifInstr_i[30:25], ifInstr_i[11:8], 1'b0};
            end
            rvPkg::OP_JAL: begin
                idExD.regWrite = 1'b1;
                idExD.isJal    = 1'b1;
                idExD.imm      = {{11{ifInstr_i[31]}}, ifInstr_i[31], ifInstr_i[19:12],
                                  ifInstr_i[20], ifInstr_i[30:21], 1'b0};
            end
            default: ;  // Unknown opcodes pass as a nop
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || stall_i || flush_i) begin
            idEx_o.valid <= 1'b0;  // Bubble
        end else begin
            idEx_o <= idExD;
        end
    end

endmodule

// File: hdl/executeStage.sv
// Execute stage with operand forwarding, ALU, branch decision and the EX/MEM register
`timescale 1ns/1ps

module executeStage (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  rvPkg::idExT            idEx_i,
    input  rvPkg::fwdSelE          fwdA_i,
    input  rvPkg::fwdSelE          fwdB_i,
    input  logic [rvPkg::XLEN-1:0] exMemFwd_i,
    input  logic [rvPkg::XLEN-1:0] memWbFwd_i,
    output logic                   redirect_o,
    output logic [rvPkg::XLEN-1:0] target_o,
    output rvPkg::exMemT           exMem_o
);

    logic [rvPkg::XLEN-1:0] opA;
    logic [rvPkg::XLEN-1:0] rs2Fwd;
    logic [rvPkg::XLEN-1:0] opB;
    logic [rvPkg::XLEN-1:0] aluOut;
    logic                   taken;
    rvPkg::exMemT           exMemD;

    always_comb begin
        case (fwdA_i)
            rvPkg::FWD_EXMEM: opA = exMemFwd_i;
            rvPkg::FWD_MEMWB: opA = memWbFwd_i;
            default:          opA = idEx_i.rs1Val;
        endcase
        case (fwdB_i)
            rvPkg::FWD_EXMEM: rs2Fwd = exMemFwd_i;
            rvPkg::FWD_MEMWB: rs2Fwd = memWbFwd_i;
            default:          rs2Fwd = idEx_i.rs2Val;
        endcase
    end

    assign opB = idEx_i.useImm ? idEx_i.imm : rs2Fwd;

    always_comb begin
        case (idEx_i.aluOp)
            rvPkg::ALU_SUB: aluOut = opA - opB;
            rvPkg::ALU_AND: aluOut = opA & opB;
            rvPkg::ALU_OR:  aluOut = opA | opB;
            rvPkg::ALU_XOR: aluOut = opA ^ opB;
            rvPkg::ALU_SLT: aluOut = {31'b0, $signed(opA) < $signed(opB)};
            rvPkg::ALU_SLL: aluOut = opA << opB[4:0];
            rvPkg::ALU_SRL: aluOut = opA >> opB[4:0];
            default:        aluOut = opA + opB;
        endcase
    end

    // beq compares equal, bne inverts it
    assign taken      = idEx_i.isBranch && ((opA == rs2Fwd) != idEx_i.branchNe);
    assign redirect_o = idEx_i.valid && (taken || idEx_i.isJal);
    assign target_o   = idEx_i.pc + idEx_i.imm;

    always_comb begin
        exMemD.valid     = idEx_i.valid;
        exMemD.rd        = idEx_i.rd;
        exMemD.regWrite  = idEx_i.regWrite;
        exMemD.memRead   = idEx_i.memRead;
        exMemD.memWrite  = idEx_i.memWrite;
        exMemD.storeData = rs2Fwd;
        if (idEx_i.isLui) begin
            exMemD.result = idEx_i.imm;
        end else if (idEx_i.isJal) begin
            exMemD.result = idEx_i.pc + 32'd4;  // Link address
        end else begin
            exMemD.result = aluOut;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exMem_o.valid <= 1'b0;
        end else begin
            exMem_o <= exMemD;
        end
    end

endmodule

// File: hdl/memoryStage.sv
// Memory stage with the data RAM, writeback value select and the MEM/WB register
`timescale 1ns/1ps

module memoryStage (
    input  logic         clk_i,
    input  logic         reset_i,
    input  rvPkg::exMemT exMem_i,
    output rvPkg::memWbT memWb_o
);

    localparam int IDX_W = $clog2(rvPkg::DMEM_WORDS);

    logic [rvPkg::XLEN-1:0] dmem [rvPkg::DMEM_WORDS];
    logic [IDX_W-1:0]       idx;
    logic [rvPkg::XLEN-1:0] loadData;

    assign idx      = exMem_i.result[IDX_W+1:2];  // Word index
    assign loadData = dmem[idx];

    always_ff @(posedge clk_i) begin
        if (exMem_i.valid && exMem_i.memWrite) begin
            dmem[idx] <= exMem_i.storeData;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            memWb_o.valid    <= 1'b0;
            memWb_o.regWrite <= 1'b0;
        end else begin
            memWb_o.valid    <= exMem_i.valid;
            memWb_o.regWrite <= exMem_i.valid && exMem_i.regWrite && (exMem_i.rd != '0);
        end
        memWb_o.rd   <= exMem_i.rd;
        memWb_o.data <= exMem_i.memRead ? loadData : exMem_i.result;
    end

    // Only lw and sw exist, so every access is a full word
    wordAligned: assert property (@(posedge clk_i) disable iff (reset_i)
        exMem_i.valid && (exMem_i.memRead || exMem_i.memWrite) |-> exMem_i.result[1:0] == 2'b00);

endmodule

// File: hdl/hazardUnit.sv
// Hazard unit producing forward selects, the load-use stall and the flush
`timescale 1ns/1ps

module hazardUnit (
    input  logic [rvPkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rvPkg::REG_ADDR_W-1:0] rs2_i,
    input  rvPkg::idExT                  idEx_i,
    input  rvPkg::exMemT                 exMem_i,
    input  rvPkg::memWbT                 memWb_i,
    input  logic                         redirect_i,
    output logic                         stall_o,
    output logic                         flush_o,
    output rvPkg::fwdSelE                fwdA_o,
    output rvPkg::fwdSelE                fwdB_o
);

    logic exMemWr;
    logic memWbWr;

    assign exMemWr = exMem_i.valid && exMem_i.regWrite && (exMem_i.rd != '0);
    assign memWbWr = memWb_i.valid && memWb_i.regWrite && (memWb_i.rd != '0);

    // Load in execute feeding decode waits one cycle, then takes MEM/WB
    assign stall_o = idEx_i.valid && idEx_i.memRead && (idEx_i.rd != '0)
                   && (idEx_i.rd == rs1_i || idEx_i.rd == rs2_i);
    assign flush_o = redirect_i;

    always_comb begin
        fwdA_o = rvPkg::FWD_RF;
        fwdB_o = rvPkg::FWD_RF;
        if (exMemWr && exMem_i.rd == idEx_i.rs1)      fwdA_o = rvPkg::FWD_EXMEM;
        else if (memWbWr && memWb_i.rd == idEx_i.rs1) fwdA_o = rvPkg::FWD_MEMWB;
        if (exMemWr && exMem_i.rd == idEx_i.rs2)      fwdB_o = rvPkg::FWD_EXMEM;
        else if (memWbWr && memWb_i.rd == idEx_i.rs2) fwdB_o = rvPkg::FWD_MEMWB;
    end

    // A load and a redirecting branch never occupy execute together
    always_comb begin
        stallFlushExclusive: assert final (!(stall_o && flush_o));
    end

endmodule

// File: hdl/rvCore.sv
// Five-stage RV32I pipeline top level joining the stages and the hazard unit
`timescale 1ns/1ps

module rvCore (
    input  logic                         clk_i,
    input  logic                         reset_i,
    output logic [rvPkg::XLEN-1:0]       imemAddr_o,
    input  logic [rvPkg::XLEN-1:0]       imemData_i,
    output logic                         retireValid_o,
    output logic [rvPkg::REG_ADDR_W-1:0] retireRd_o,
    output logic [rvPkg::XLEN-1:0]       retireData_o
);

    logic                         stall;
    logic                         flush;
    logic                         redirect;
    logic [rvPkg::XLEN-1:0]       target;
    logic [rvPkg::XLEN-1:0]       ifPc;
    logic [rvPkg::XLEN-1:0]       ifInstr;
    logic                         ifValid;
    logic [rvPkg::REG_ADDR_W-1:0] rs1;
    logic [rvPkg::REG_ADDR_W-1:0] rs2;
    rvPkg::idExT                  idEx;
    rvPkg::exMemT                 exMem;
    rvPkg::memWbT                 memWb;
    rvPkg::fwdSelE                fwdA;
    rvPkg::fwdSelE                fwdB;

    fetchStage fetch (
        .clk_i(clk_i), .reset_i(reset_i), .stall_i(stall), .flush_i(flush),
        .redirect_i(redirect), .target_i(target),
        .imemAddr_o(imemAddr_o), .imemData_i(imemData_i),
        .ifPc_o(ifPc), .ifInstr_o(ifInstr), .ifValid_o(ifValid)
    );

    decodeStage decode (
        .clk_i(clk_i), .reset_i(reset_i), .stall_i(stall), .flush_i(flush),
        .ifPc_i(ifPc), .ifInstr_i(ifInstr), .ifValid_i(ifValid), .wb_i(memWb),
        .rs1_o(rs1), .rs2_o(rs2), .idEx_o(idEx)
    );

    executeStage execute (
        .clk_i(clk_i), .reset_i(reset_i), .idEx_i(idEx), .fwdA_i(fwdA), .fwdB_i(fwdB),
        .exMemFwd_i(exMem.result), .memWbFwd_i(memWb.data),
        .redirect_o(redirect), .target_o(target), .exMem_o(exMem)
    );

    memoryStage memory (
        .clk_i(clk_i), .reset_i(reset_i), .exMem_i(exMem), .memWb_o(memWb)
    );

    hazardUnit hazard (
        .rs1_i(rs1), .rs2_i(rs2), .idEx_i(idEx), .exMem_i(exMem), .memWb_i(memWb),
        .redirect_i(redirect), .stall_o(stall), .flush_o(flush),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

    // regWrite in MEM/WB is already qualified by valid and a nonzero rd
    assign retireValid_o = memWb.regWrite;
    assign retireRd_o    = memWb.rd;
    assign retireData_o  = memWb.data;

endmodule

// File: dv/rvProgram.svh
// Test program image and an in-order instruction-set model of the expected retire list
`ifndef RV_PROGRAM_SVH
`define RV_PROGRAM_SVH

localparam int PROG_WORDS = 64;
localparam logic [31:0] NOP = 32'h00000013;  // addi x0, x0, 0

logic [31:0] prog [PROG_WORDS];
int          progLen = 0;
logic [4:0]  expRd [PROG_WORDS];
logic [31:0] expData [PROG_WORDS];
int          expCount = 0;

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rvPkg::OP_REG};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::OP_STORE};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::OP_BRANCH};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::OP_JAL};
endfunction

task automatic emit(input logic [31:0] word);
    prog[progLen] = word;
    progLen++;
endtask

// RV32I semantics by funct3, bit 30 picks sub
function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                       input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return sub ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

task automatic runReference(input logic [31:0] endWord);
    logic [31:0] r [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] next;
    logic        wr;
    int          steps;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 256; i++) mem[i] = '0;
    pc = '0;
    steps = 0;
    while (steps < 1000 && (pc >> 2) < progLen && prog[pc >> 2] != endWord) begin
        ins  = prog[pc >> 2];
        a    = r[ins[19:15]];
        b    = r[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        wr   = 1'b0;
        res  = '0;
        next = pc + 32'd4;
        case (ins[6:0])
            rvPkg::OP_REG: begin
                wr = 1'b1;
                res = aluRef(ins[14:12], ins[30], a, b);
            end
            rvPkg::OP_IMM: begin
                wr = 1'b1;
                res = aluRef(ins[14:12], 1'b0, a, immI);
            end
            rvPkg::OP_LUI: begin
                wr = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            rvPkg::OP_LOAD: begin
                addr = a + immI;
                wr = 1'b1;
                res = mem[addr[9:2]];
            end
            rvPkg::OP_STORE: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mem[addr[9:2]] = b;
            end
            rvPkg::OP_BRANCH: begin
                if ((a == b) != ins[12]) begin  // funct3 bit 0 set means bne
                    next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            rvPkg::OP_JAL: begin
                wr = 1'b1;
                res = pc + 32'd4;
                next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            r[ins[11:7]] = res;
            expRd[expCount] = ins[11:7];
            expData[expCount] = res;
            expCount++;
        end
        pc = next;
        steps++;
    end
endtask

`endif

// File: dv/rvCoreTb.sv
// Testbench for the RV32I pipeline with a program model and retire checking assertions
`timescale 1ns/1ps

module rvCoreTb;

    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 6;

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic [31:0] imemAddr_o;
    logic [31:0] imemData_i;
    logic        retireValid_o;
    logic [4:0]  retireRd_o;
    logic [31:0] retireData_o;

    int          seed = 32'h5ed9;
    int          errors = 0;
    int          retireIdx = 0;
    logic [31:0] endPc;
    logic [31:0] endWord;
    logic [31:0] lwWord;
    logic [4:0]  expRdNow;
    logic [31:0] expDataNow;

    `include "rvProgram.svh"

    rvCore dut (
        .clk_i(clk_i), .reset_i(reset_i), .imemAddr_o(imemAddr_o), .imemData_i(imemData_i),
        .retireValid_o(retireValid_o), .retireRd_o(retireRd_o), .retireData_o(retireData_o)
    );

    always #10 clk_i = ~clk_i;

    // Instruction ROM answers in the same cycle
    assign imemData_i = (imemAddr_o[31:2] < progLen) ? prog[imemAddr_o[7:2]] : NOP;

    assign expRdNow   = (retireIdx < PROG_WORDS) ? expRd[retireIdx] : '0;
    assign expDataNow = (retireIdx < PROG_WORDS) ? expData[retireIdx] : '0;

    always @(posedge clk_i) begin
        if (!reset_i && retireValid_o) retireIdx <= retireIdx + 1;
    end

    quietInReset: assert property (@(posedge clk_i) reset_i |=> !retireValid_o)
        else begin errors++; $display("retire strobe seen while in reset at %0t", $time); end
    startAddr: assert property (@(posedge clk_i) $fell(reset_i) |-> imemAddr_o == rvPkg::RESET_PC)
        else begin errors++; $display("first fetch address after reset is not the reset pc"); end
    noX0Strobe: assert property (@(posedge clk_i) disable iff (reset_i)
        retireValid_o |-> retireRd_o != 5'd0)
        else begin errors++; $display("retire strobe for a write to x0 at %0t", $time); end
    noExtra: assert property (@(posedge clk_i) disable iff (reset_i)
        retireValid_o |-> retireIdx < expCount)
        else begin errors++; $display("more retire strobes than expected at %0t", $time); end
    rdMatch: assert property (@(posedge clk_i) disable iff (reset_i)
        retireValid_o && retireIdx < expCount |-> retireRd_o == expRdNow)
        else begin
            errors++;
            $display("error at %0t: retireRd_o = %0d, expected %0d", $time,
                     $sampled(retireRd_o), $sampled(expRdNow));
        end
    dataMatch: assert property (@(posedge clk_i) disable iff (reset_i)
        retireValid_o && retireIdx < expCount |-> retireData_o == expDataNow)
        else begin
            errors++;
            $display("error at %0t: retireData_o = %h, expected %h", $time,
                     $sampled(retireData_o), $sampled(expDataNow));
        end

    task automatic buildProgram();
        logic [31:0] hi;
        lwWord = $random(seed);
        hi = lwWord + 32'h800;  // Round so addi restores the low half
        emit(encI(12'($random(seed)), 5'd0, 3'b000, 5'd1, rvPkg::OP_IMM));
        emit(encI(12'($random(seed)), 5'd0, 3'b000, 5'd2, rvPkg::OP_IMM));
        emit(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));   // add, both forward paths
        emit(encR(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));   // sub
        emit(encR(7'h00, 5'd2, 5'd4, 3'b111, 5'd5));
        emit(encR(7'h00, 5'd3, 5'd5, 3'b110, 5'd6));
        emit(encR(7'h00, 5'd4, 5'd6, 3'b100, 5'd7));
        emit(encR(7'h00, 5'd1, 5'd7, 3'b010, 5'd8));   // slt
        emit(encR(7'h00, 5'd2, 5'd1, 3'b001, 5'd9));   // sll
        emit(encR(7'h00, 5'd2, 5'd9, 3'b101, 5'd10));  // srl
        emit(encI(12'($random(seed)), 5'd10, 3'b111, 5'd11, rvPkg::OP_IMM));
        emit(encI(12'($random(seed)), 5'd11, 3'b110, 5'd12, rvPkg::OP_IMM));
        emit(encI(12'($random(seed)), 5'd12, 3'b100, 5'd13, rvPkg::OP_IMM));
        emit(encI(12'($random(seed)), 5'd13, 3'b010, 5'd14, rvPkg::OP_IMM));
        emit(encI(12'd3, 5'd13, 3'b001, 5'd15, rvPkg::OP_IMM));
        emit(encI(12'd7, 5'd15, 3'b101, 5'd16, rvPkg::OP_IMM));
        emit({hi[31:12], 5'd17, rvPkg::OP_LUI});
        emit(encI(lwWord[11:0], 5'd17, 3'b000, 5'd17, rvPkg::OP_IMM));
        emit(encI(12'h040, 5'd0, 3'b000, 5'd18, rvPkg::OP_IMM));
        emit(encS(12'd0, 5'd17, 5'd18));
        emit(encI(12'd0, 5'd18, 3'b010, 5'd19, rvPkg::OP_LOAD));
        emit(encR(7'h00, 5'd1, 5'd19, 3'b000, 5'd20)); // Load-use
        emit(encS(12'd4, 5'd3, 5'd18));
        emit(encI(12'd4, 5'd18, 3'b010, 5'd21, rvPkg::OP_LOAD));
        emit(encI(12'd5, 5'd21, 3'b000, 5'd0, rvPkg::OP_IMM));  // Write to x0
        emit(encR(7'h00, 5'd21, 5'd0, 3'b000, 5'd22));
        emit(encB(13'd12, 5'd1, 5'd1, 3'b000));          // beq taken
        emit(encI(12'd1, 5'd0, 3'b000, 5'd23, rvPkg::OP_IMM));
        emit(encI(12'd2, 5'd0, 3'b000, 5'd24, rvPkg::OP_IMM));
        emit(encB(13'd8, 5'd1, 5'd1, 3'b001));           // bne not taken
        emit(encI(12'd3, 5'd0, 3'b000, 5'd25, rvPkg::OP_IMM));
        emit(encB(13'd12, 5'd2, 5'd1, 3'b001));
        emit(encI(12'd4, 5'd0, 3'b000, 5'd26, rvPkg::OP_IMM));
        emit(encI(12'd5, 5'd0, 3'b000, 5'd27, rvPkg::OP_IMM));
        emit(encJ(21'd12, 5'd28));
        emit(encI(12'd6, 5'd0, 3'b000, 5'd29, rvPkg::OP_IMM));
        emit(encI(12'd7, 5'd0, 3'b000, 5'd30, rvPkg::OP_IMM));
        emit(encR(7'h00, 5'd20, 5'd28, 3'b000, 5'd31));
        endPc = progLen * 4;
        emit(endWord);  // jal x0, 0 spins here
    endtask

    initial begin
        reset_i = 1'b1;
        endWord = encJ(21'd0, 5'd0);
        for (int i = 0; i < PROG_WORDS; i++) prog[i] = NOP;
        buildProgram();
        runReference(endWord);
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;
        while (imemAddr_o != endPc) @(negedge clk_i);
        repeat (DRAIN_CYCLES) @(negedge clk_i);
        retireCount: assert (retireIdx == expCount)
            else begin
                errors++;
                $display("retired %0d register writes, expected %0d", retireIdx, expCount);
            end
        $display("errors: %0d, retired %0d of %0d", errors, retireIdx, expCount);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (reset_i === 1'b0);
        repeat (progLen * 4 + 100) @(posedge clk_i);
        $display("timeout, end of program never reached, errors: %0d", errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sim.f
+incdir+dv
hdl/rvPkg.sv
hdl/regFile.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/hazardUnit.sv
hdl/rvCore.sv
dv/rvCoreTb.sv

// File: Makefile
# Verilator build and run for the RV32I pipeline core
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := dv/rvProgram.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
